// ==== memtest.f ====
rtl/memtest_pkg.sv
rtl/memtest_addr_counter.sv
rtl/memtest_pattern_gen.sv
rtl/memtest_checker.sv
rtl/memtest_fsm.sv
rtl/memtest_top.sv
verification/memtest_sva.sv
verification/memtest_clk_gen.sv
verification/memtest_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the memtest testbench with Verilator and runs it from the project root
# Exit status is nonzero when the build fails, the run fails or the log reports a failure

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module memtest_tb \
  -f memtest.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vmemtest_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TEST FAILED" "$SIM_LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== verification/memtest_tb.sv ====
// Testbench of memtest_top with a word memory that acks each strobe after 1 to 3 cycles
// Every table row runs exactly one pass; the run stops at the first mismatch or timeout

module memtest_tb import memtest_pkg::*; ();

  typedef struct packed {
    logic              lfsr_mode;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] stop_addr;
    logic              fault_en;
    logic [ADDR_W-1:0] fault_addr;
    logic [CNT_W-1:0]  exp_errors;
  } test_row_t;

  logic              clk_sys;
  logic              rst_sys_n;
  test_cfg_t         cfg;
  logic              run;
  logic              clear_fail;
  logic              single_write;
  logic              single_read;
  logic [DATA_W-1:0] single_wdata;
  logic [DATA_W-1:0] single_rdata;
  mem_req_t          mem_req;
  logic              mem_ack = 1'b0;
  logic [DATA_W-1:0] mem_rdata = '0;
  test_status_t      status;
  logic              idle;

  // Memory model
  logic [DATA_W-1:0] mem [2**ADDR_W];
  mem_req_t          pend_req;
  logic              mem_busy = 1'b0;
  logic [1:0]        ack_delay;
  logic              fault_en;
  logic [ADDR_W-1:0] fault_addr;
  integer            seed = 32'hd0efabd4;

  test_row_t         test_table [4];
  int unsigned       iter_exp;
  logic [DATA_W-1:0] man_word;

  memtest_clk_gen i_clk_gen (
    .clk_sys_o (clk_sys),
    .rst_sys_no(rst_sys_n)
  );

  memtest_top i_dut (
    .clk_sys_i     (clk_sys),
    .rst_sys_ni    (rst_sys_n),
    .cfg_i         (cfg),
    .run_i         (run),
    .clear_fail_i  (clear_fail),
    .single_write_i(single_write),
    .single_read_i (single_read),
    .single_wdata_i(single_wdata),
    .single_rdata_o(single_rdata),
    .mem_req_o     (mem_req),
    .mem_ack_i     (mem_ack),
    .mem_rdata_i   (mem_rdata),
    .status_o      (status),
    .idle_o        (idle)
  );

  function automatic logic [1:0] draw_ack_delay();
    int unsigned r;
    r = $unsigned($random(seed));
    return 2'(r % 3 + 1);
  endfunction

  // Galois step shifts right and XORs the mask when a 1 falls out
  function automatic logic [DATA_W-1:0] lfsr_advance(input logic [DATA_W-1:0] v);
    logic [DATA_W-1:0] n;
    n = v >> 1;
    if (v[0]) begin
      n = n ^ LFSR_POLY;
    end
    return n;
  endfunction

  // Faulty word keeps bit 0 inverted
  always @(posedge clk_sys) begin
    mem_ack <= 1'b0;
    if (mem_busy) begin
      if (ack_delay == 2'd1) begin
        mem_ack  <= 1'b1;
        mem_busy <= 1'b0;
        if (pend_req.we) begin
          if (fault_en && (pend_req.addr == fault_addr)) begin
            mem[pend_req.addr] <= pend_req.wdata ^ 32'h1;
          end else begin
            mem[pend_req.addr] <= pend_req.wdata;
          end
        end else begin
          mem_rdata <= mem[pend_req.addr];
        end
      end else begin
        ack_delay <= ack_delay - 2'd1;
      end
    end else if (mem_req.we || mem_req.re) begin
      mem_busy  <= 1'b1;
      pend_req  <= mem_req;
      ack_delay <= draw_ack_delay();
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] expected);
    string line;
    if (got !== expected) begin
      line = $sformatf("FAIL time=%0t signal=%s got=%h expected=%h",
                       $time, name, got, expected);
      stop_with_failure(line);
    end
  endtask

  task automatic wait_for_reset();
    int n;
    n = 0;
    @(negedge clk_sys);
    while (!rst_sys_n) begin
      n++;
      if (n > 100) begin
        stop_with_failure("Timeout: reset was never released");
      end
      @(negedge clk_sys);
    end
  endtask

  task automatic wait_until_busy();
    int n;
    n = 0;
    @(negedge clk_sys);
    while (idle) begin
      n++;
      if (n > 100) begin
        stop_with_failure("Timeout: the engine never left idle");
      end
      @(negedge clk_sys);
    end
  endtask

  task automatic wait_until_idle();
    int n;
    n = 0;
    @(negedge clk_sys);
    while (!idle) begin
      n++;
      if (n > 1000) begin
        stop_with_failure("Timeout: the engine did not return to idle");
      end
      @(negedge clk_sys);
    end
  endtask

  task automatic wait_for_iterations(input int unsigned target);
    int n;
    n = 0;
    @(negedge clk_sys);
    while (status.iterations != target) begin
      n++;
      if (n > 1000) begin
        stop_with_failure("Timeout: the pass counter did not reach its next value");
      end
      @(negedge clk_sys);
    end
  endtask

  // Words the memory must hold after one pass over the row's range
  task automatic check_stored(input test_row_t row);
    logic [DATA_W-1:0] lfsr;
    logic [DATA_W-1:0] exp_word;
    logic [ADDR_W-1:0] a;
    lfsr = LFSR_SEED;
    for (int n = 0; n <= int'(row.stop_addr - row.start_addr); n++) begin
      a = row.start_addr + ADDR_W'(n);
      exp_word = row.lfsr_mode ? lfsr : DATA_W'(a);
      if (row.fault_en && (a == row.fault_addr)) begin
        exp_word[0] = ~exp_word[0];
      end
      check_value($sformatf("mem[%h]", a), mem[a], exp_word);
      lfsr = lfsr_advance(lfsr);
    end
  endtask

  task automatic run_row(input test_row_t row, input int unsigned iter_target);
    @(posedge clk_sys);
    cfg        <= '{row.lfsr_mode, row.start_addr, row.stop_addr};
    fault_en   <= row.fault_en;
    fault_addr <= row.fault_addr;
    clear_fail <= 1'b1;
    @(posedge clk_sys);
    clear_fail <= 1'b0;
    @(negedge clk_sys);
    check_value("fail", status.fail, 1'b0);
    check_value("total_errors", status.total_errors, 0);
    check_value("error_addr", status.error_addr, 0);
    @(posedge clk_sys);
    run <= 1'b1;
    wait_until_busy();
    // Drop run early so the engine stops after this pass
    @(posedge clk_sys);
    run <= 1'b0;
    wait_for_iterations(iter_target);
    wait_until_idle();
    check_value("pass", status.pass, row.exp_errors == 0);
    check_value("fail", status.fail, row.exp_errors != 0);
    check_value("total_errors", status.total_errors, row.exp_errors);
    check_value("error_addr", status.error_addr,
                (row.exp_errors != 0) ? row.fault_addr : '0);
    check_value("iterations", status.iterations, iter_target);
    // Last address of the read phase stays in the counter
    check_value("current_addr", status.current_addr, row.stop_addr);
    check_stored(row);
  endtask

  initial begin
    cfg          = '0;
    run          = 1'b0;
    clear_fail   = 1'b0;
    single_write = 1'b0;
    single_read  = 1'b0;
    single_wdata = '0;
    fault_en     = 1'b0;
    fault_addr   = '0;
    test_table[0] = '{1'b0, 16'h0010, 16'h0017, 1'b0, 16'h0000, 32'd0};
    test_table[1] = '{1'b1, 16'h0100, 16'h010f, 1'b0, 16'h0000, 32'd0};
    // One bad bit inside an LFSR range
    test_table[2] = '{1'b1, 16'h0200, 16'h0207, 1'b1, 16'h0203, 32'd1};
    // Clean pass after the fail flag is cleared
    test_table[3] = '{1'b0, 16'h0300, 16'h0305, 1'b0, 16'h0000, 32'd0};

    wait_for_reset();
    check_value("idle_o", idle, 1'b1);
    check_value("pass", status.pass, 1'b0);
    check_value("fail", status.fail, 1'b0);
    check_value("iterations", status.iterations, 0);
    check_value("total_errors", status.total_errors, 0);

    iter_exp = 0;
    foreach (test_table[i]) begin
      iter_exp++;
      run_row(test_table[i], iter_exp);
    end

    // Manual write, then manual read back at start_addr
    man_word = $random(seed);
    @(posedge clk_sys);
    cfg          <= '{1'b0, 16'h0400, 16'h0400};
    fault_en     <= 1'b0;
    single_wdata <= man_word;
    single_write <= 1'b1;
    @(posedge clk_sys);
    single_write <= 1'b0;
    wait_until_busy();
    wait_until_idle();
    check_value("mem[0400]", mem[16'h0400], man_word);
    @(posedge clk_sys);
    single_read <= 1'b1;
    @(posedge clk_sys);
    single_read <= 1'b0;
    wait_until_busy();
    wait_until_idle();
    check_value("single_rdata_o", single_rdata, man_word);
    check_value("iterations", status.iterations, iter_exp);
    check_value("current_addr", status.current_addr, 16'h0400);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== verification/memtest_clk_gen.sv ====
// Testbench clock of period 20 and active-low reset held for 4 rising edges

module memtest_clk_gen (
  output logic clk_sys_o,
  output logic rst_sys_no
);

  initial begin
    clk_sys_o = 1'b0;
    forever #10 clk_sys_o = ~clk_sys_o;
  end

  initial begin
    rst_sys_no = 1'b0;
    repeat (4) @(posedge clk_sys_o);
    rst_sys_no <= 1'b1;
  end

endmodule

// ==== verification/memtest_sva.sv ====
// Memory port rules of memtest_top, bound into the design by module name
// Rules are off while reset is asserted

module memtest_sva import memtest_pkg::*; (
  input logic     clk_sys_i,
  input logic     rst_sys_ni,
  input mem_req_t mem_req_i,
  input logic     mem_ack_i,
  input logic     idle_i
);

  logic strobe;
  logic outstanding_q;

  assign strobe = mem_req_i.we || mem_req_i.re;

  // Set by a strobe, cleared by its ack
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      outstanding_q <= 1'b0;
    end else if (strobe) begin
      outstanding_q <= 1'b1;
    end else if (mem_ack_i) begin
      outstanding_q <= 1'b0;
    end
  end

  a_we_re_exclusive: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) !(mem_req_i.we && mem_req_i.re)
  ) else $error("we and re are high in the same cycle");

  a_one_outstanding: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) outstanding_q |-> !strobe
  ) else $error("new strobe issued before the previous access was acked");

  a_busy_on_strobe: assert property (
    @(posedge clk_sys_i) disable iff (!rst_sys_ni) strobe |-> !idle_i
  ) else $error("strobe issued while idle_o is high");

endmodule

bind memtest_top memtest_sva i_sva (
  .clk_sys_i (clk_sys_i),
  .rst_sys_ni(rst_sys_ni),
  .mem_req_i (mem_req_o),
  .mem_ack_i (mem_ack_i),
  .idle_i    (idle_o)
);

// ==== rtl/memtest_top.sv ====
// Memory read/write test engine with a strobe/ack memory port, one access outstanding
// cfg_i must be held stable while run_i is high or a manual access is in flight

module memtest_top import memtest_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  test_cfg_t         cfg_i,
  input  logic              run_i,
  input  logic              clear_fail_i,
  input  logic              single_write_i,
  input  logic              single_read_i,
  input  logic [DATA_W-1:0] single_wdata_i,
  output logic [DATA_W-1:0] single_rdata_o,
  output mem_req_t          mem_req_o,
  input  logic              mem_ack_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  output test_status_t      status_o,
  output logic              idle_o
);

  logic              load;
  logic              step;
  logic              pass_done;
  logic              restart;
  logic              advance;
  logic              rd_check;
  logic              pass_start;
  logic              at_stop;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] pattern;
  logic [CNT_W-1:0]  iterations;
  test_status_t      chk_status;
  logic              rd_pend_q;
  logic [DATA_W-1:0] single_rdata_q;

  memtest_fsm i_fsm (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .run_i         (run_i),
    .single_write_i(single_write_i),
    .single_read_i (single_read_i),
    .single_wdata_i(single_wdata_i),
    .at_stop_i     (at_stop),
    .mem_ack_i     (mem_ack_i),
    .addr_i        (addr),
    .pattern_i     (pattern),
    .mem_req_o     (mem_req_o),
    .load_o        (load),
    .step_o        (step),
    .pass_done_o   (pass_done),
    .restart_o     (restart),
    .advance_o     (advance),
    .rd_check_o    (rd_check),
    .pass_start_o  (pass_start),
    .idle_o        (idle_o)
  );

  memtest_addr_counter i_addr_counter (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .cfg_i       (cfg_i),
    .load_i      (load),
    .step_i      (step),
    .pass_done_i (pass_done),
    .addr_o      (addr),
    .at_stop_o   (at_stop),
    .iterations_o(iterations)
  );

  memtest_pattern_gen i_pattern_gen (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .lfsr_mode_i(cfg_i.lfsr_mode),
    .addr_i     (addr),
    .restart_i  (restart),
    .advance_i  (advance),
    .pattern_o  (pattern)
  );

  memtest_checker i_checker (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .rd_check_i  (rd_check),
    .pass_start_i(pass_start),
    .pass_done_i (pass_done),
    .clear_fail_i(clear_fail_i),
    .rdata_i     (mem_rdata_i),
    .expected_i  (pattern),
    .addr_i      (addr),
    .status_o    (chk_status)
  );

  // Outstanding access is a read
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rd_pend_q <= 1'b0;
    end else if (mem_req_o.re) begin
      rd_pend_q <= 1'b1;
    end else if (mem_ack_i) begin
      rd_pend_q <= 1'b0;
    end
  end

  // Read acks not flagged for checking belong to a manual read
  always_ff @(posedge clk_sys_i) begin
    if (mem_ack_i && rd_pend_q && !rd_check) begin
      single_rdata_q <= mem_rdata_i;
    end
  end

  assign single_rdata_o = single_rdata_q;

  always_comb begin
    status_o              = chk_status;
    status_o.iterations   = iterations;
    status_o.current_addr = addr;
  end

endmodule

// ==== rtl/memtest_fsm.sv ====
// Sequencer of the memory test: write phase, read phase, and single manual accesses
// Only one access is outstanding; every state waiting on mem_ack_i waits without limit

module memtest_fsm import memtest_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              run_i,
  input  logic              single_write_i,
  input  logic              single_read_i,
  input  logic [DATA_W-1:0] single_wdata_i,
  input  logic              at_stop_i,
  input  logic              mem_ack_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] pattern_i,
  output mem_req_t          mem_req_o,
  output logic              load_o,
  output logic              step_o,
  output logic              pass_done_o,
  output logic              restart_o,
  output logic              advance_o,
  output logic              rd_check_o,
  output logic              pass_start_o,
  output logic              idle_o
);

  fsm_state_e        state_q;
  fsm_state_e        state_d;
  logic              man_take;
  logic              man_strobe_q;
  logic              man_write_q;
  logic [DATA_W-1:0] man_wdata_q;

  // Manual pulses count only while idle and not running
  assign man_take = (state_q == ST_IDLE) && !run_i && (single_write_i || single_read_i);

  always_comb begin
    state_d      = state_q;
    load_o       = 1'b0;
    step_o       = 1'b0;
    pass_done_o  = 1'b0;
    restart_o    = 1'b0;
    advance_o    = 1'b0;
    rd_check_o   = 1'b0;
    pass_start_o = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (run_i) begin
          state_d      = ST_WR_REQ;
          load_o       = 1'b1;
          restart_o    = 1'b1;
          pass_start_o = 1'b1;
        end else if (man_take) begin
          // Manual access goes to start_addr
          state_d = ST_MAN_WAIT;
          load_o  = 1'b1;
        end
      end
      ST_WR_REQ: state_d = ST_WR_WAIT;
      ST_WR_WAIT: begin
        if (mem_ack_i) begin
          if (at_stop_i) begin
            state_d   = ST_RD_REQ;
            load_o    = 1'b1;
            restart_o = 1'b1;
          end else begin
            state_d   = ST_WR_REQ;
            step_o    = 1'b1;
            advance_o = 1'b1;
          end
        end
      end
      ST_RD_REQ: state_d = ST_RD_WAIT;
      ST_RD_WAIT: begin
        if (mem_ack_i) begin
          rd_check_o = 1'b1;
          if (at_stop_i) begin
            pass_done_o = 1'b1;
            if (run_i) begin
              state_d      = ST_WR_REQ;
              load_o       = 1'b1;
              restart_o    = 1'b1;
              pass_start_o = 1'b1;
            end else begin
              state_d = ST_IDLE;
            end
          end else begin
            state_d   = ST_RD_REQ;
            step_o    = 1'b1;
            advance_o = 1'b1;
          end
        end
      end
      ST_MAN_WAIT: begin
        if (mem_ack_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      state_q      <= ST_IDLE;
      man_strobe_q <= 1'b0;
      man_write_q  <= 1'b0;
    end else begin
      state_q      <= state_d;
      man_strobe_q <= man_take;
      if (man_take) begin
        // Write wins if both pulses arrive together
        man_write_q <= single_write_i;
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (man_take && single_write_i) begin
      man_wdata_q <= single_wdata_i;
    end
  end

  // Automatic strobes come from the state, the manual one from its pulse flop
  assign mem_req_o.we    = (state_q == ST_WR_REQ) || (man_strobe_q && man_write_q);
  assign mem_req_o.re    = (state_q == ST_RD_REQ) || (man_strobe_q && !man_write_q);
  assign mem_req_o.addr  = addr_i;
  assign mem_req_o.wdata = (state_q == ST_MAN_WAIT) ? man_wdata_q : pattern_i;

  assign idle_o = (state_q == ST_IDLE);

endmodule

// ==== rtl/memtest_checker.sv ====
// Read data checker with error count, first error address and pass/fail flags
// fail stays set until clear_fail_i; pass is decided once per completed pass

module memtest_checker import memtest_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              rd_check_i,
  input  logic              pass_start_i,
  input  logic              pass_done_i,
  input  logic              clear_fail_i,
  input  logic [DATA_W-1:0] rdata_i,
  input  logic [DATA_W-1:0] expected_i,
  input  logic [ADDR_W-1:0] addr_i,
  output test_status_t      status_o
);

  logic              mismatch;
  logic              pass_q;
  logic              fail_q;
  logic              pass_err_q;
  logic [CNT_W-1:0]  total_errors_q;
  logic [ADDR_W-1:0] error_addr_q;

  assign mismatch = rd_check_i && (rdata_i != expected_i);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pass_q         <= 1'b0;
      fail_q         <= 1'b0;
      pass_err_q     <= 1'b0;
      total_errors_q <= '0;
      error_addr_q   <= '0;
    end else begin
      if (clear_fail_i) begin
        fail_q         <= 1'b0;
        total_errors_q <= '0;
        error_addr_q   <= '0;
      end else if (mismatch) begin
        fail_q         <= 1'b1;
        total_errors_q <= total_errors_q + 1'b1;
        // fail low means no error seen since the last clear
        if (!fail_q) begin
          error_addr_q <= addr_i;
        end
      end
      // Last read of a pass is checked in the same cycle as pass_done_i
      if (pass_done_i) begin
        pass_q <= !(pass_err_q || mismatch);
      end
      if (pass_start_i) begin
        pass_err_q <= 1'b0;
      end else if (mismatch) begin
        pass_err_q <= 1'b1;
      end
    end
  end

  always_comb begin
    status_o              = '0;
    status_o.pass         = pass_q;
    status_o.fail         = fail_q;
    status_o.total_errors = total_errors_q;
    status_o.error_addr   = error_addr_q;
  end

endmodule

// ==== rtl/memtest_pattern_gen.sv ====
// Expected data word, either the zero-extended address or a Galois LFSR value
// The LFSR reseeds at each phase start so write and read phases see the same words

module memtest_pattern_gen import memtest_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  logic              lfsr_mode_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic              restart_i,
  input  logic              advance_i,
  output logic [DATA_W-1:0] pattern_o
);

  logic [DATA_W-1:0] lfsr_q;
  logic [DATA_W-1:0] lfsr_next;

  // Shift right, fold in the polynomial when a 1 drops out
  assign lfsr_next = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_POLY) : (lfsr_q >> 1);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      lfsr_q <= LFSR_SEED;
    end else if (restart_i) begin
      lfsr_q <= LFSR_SEED;
    end else if (advance_i) begin
      lfsr_q <= lfsr_next;
    end
  end

  assign pattern_o = lfsr_mode_i ? lfsr_q : {{(DATA_W-ADDR_W){1'b0}}, addr_i};

endmodule

// ==== rtl/memtest_addr_counter.sv ====
// Word address counter and completed-pass counter
// stop_addr must not be below start_addr, else the address wraps through the whole space

module memtest_addr_counter import memtest_pkg::*; (
  input  logic              clk_sys_i,
  input  logic              rst_sys_ni,
  input  test_cfg_t         cfg_i,
  input  logic              load_i,
  input  logic              step_i,
  input  logic              pass_done_i,
  output logic [ADDR_W-1:0] addr_o,
  output logic              at_stop_o,
  output logic [CNT_W-1:0]  iterations_o
);

  logic [ADDR_W-1:0] addr_q;
  logic [CNT_W-1:0]  iter_q;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      addr_q <= '0;
    end else if (load_i) begin
      addr_q <= cfg_i.start_addr;
    end else if (step_i) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  // Passes completed since reset
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      iter_q <= '0;
    end else if (pass_done_i) begin
      iter_q <= iter_q + 1'b1;
    end
  end

  assign addr_o       = addr_q;
  assign at_stop_o    = (addr_q == cfg_i.stop_addr);
  assign iterations_o = iter_q;

endmodule

// ==== rtl/memtest_pkg.sv ====
// Shared widths, LFSR constants and types of the memory test engine
// Addresses are word addresses; the memory port moves one full DATA_W word per access

package memtest_pkg;

  localparam int ADDR_W = 16;
  localparam int DATA_W = 32;
  localparam int CNT_W  = 32;

  // Galois LFSR with a nonzero seed
  localparam logic [DATA_W-1:0] LFSR_SEED = 32'h0000_0001;
  localparam logic [DATA_W-1:0] LFSR_POLY = 32'hA300_0000;

  // One access on the memory port with single-cycle strobes
  typedef struct packed {
    logic              we;
    logic              re;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic              lfsr_mode;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] stop_addr;
  } test_cfg_t;

  typedef struct packed {
    logic              pass;
    logic              fail;
    logic [CNT_W-1:0]  iterations;
    logic [ADDR_W-1:0] current_addr;
    logic [CNT_W-1:0]  total_errors;
    logic [ADDR_W-1:0] error_addr;
  } test_status_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WR_REQ,
    ST_WR_WAIT,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_MAN_WAIT
  } fsm_state_e;

endpackage
